/* source/peak_cfg_pkg.sv */
`default_nettype none
// *********************************************************
// Peak finder configuration
// Widths, window geometry, register map and tree latency
// *********************************************************

package peak_cfg_pkg;

	// Data path widths
	localparam int sample_width = 16;
	localparam int bus_width = 32;
	localparam int addr_width = 4;
	localparam int sel_width = bus_width / 8;

	// Window geometry, each comparator level reduces by four
	localparam int tree_levels = 2;
	localparam int window_slots = 4 ** tree_levels;
	localparam int slot_index_width = 2 * tree_levels;
	// Fill count reaches window_slots, so one extra bit
	localparam int fill_count_width = slot_index_width + 1;

	// One cycle for the buffer write, one per level
	localparam int tree_latency = tree_levels + 1;

	// Register map, byte addresses
	localparam logic [addr_width-1:0] reg_ctrl = addr_width'('h0);
	localparam logic [addr_width-1:0] reg_status = addr_width'('h4);
	localparam logic [addr_width-1:0] reg_sample = addr_width'('h8);
	localparam logic [addr_width-1:0] reg_result = addr_width'('hC);

endpackage

`default_nettype wire

/* source/peak_ctrl_pkg.sv */
`default_nettype none
// *********************************************************
// Peak finder control encodings
// Search states and host opcodes
// *********************************************************

package peak_ctrl_pkg;

	// Search state, read back in status bits 1..0
	typedef enum logic [1:0]
	{
		idle = 2'd0,
		fill = 2'd1,
		drain = 2'd2,
		done = 2'd3
	} peak_state_e;

	// Host opcodes written to the control register
	// Values outside this set decode to op_none
	typedef enum logic [2:0]
	{
		op_none = 3'd0,
		op_find_max = 3'd1,
		op_find_min = 3'd2,
		op_flush = 3'd3,
		op_clear = 3'd4
	} peak_op_e;

endpackage

`default_nettype wire

/* source/cmp4_select.sv */
`timescale 1ns/10ps
`default_nettype none
// *********************************************************
// Four-input comparator node, registered
// Picks the max, or the min, of the valid inputs
// *********************************************************

module cmp4_select
(
	input wire rvx_port_0,
	input wire rvx_port_4,
	input wire [3:0] in_valid,
	input wire [3:0][peak_cfg_pkg::sample_width-1:0] in_value,
	input wire find_min,
	output logic out_valid,
	output logic [peak_cfg_pkg::sample_width-1:0] out_value
);

	import peak_cfg_pkg::*;

	// Running winner across the four inputs
	logic best_valid;
	logic [sample_width-1:0] best_value;

	// Unsigned compare, invalid inputs never win
	// Zero value when nothing is valid
	always_comb
	begin
		best_valid = 1'b0;
		best_value = '0;
		for (int i = 0; i < 4; i++)
		begin
			if (in_valid[i])
			begin
				if (!best_valid)
					best_value = in_value[i];
				else if (find_min ? (in_value[i] < best_value) : (in_value[i] > best_value))
					best_value = in_value[i];
				best_valid = 1'b1;
			end
		end
	end

	// Valid flag of the node
	always_ff @(posedge rvx_port_0 or negedge rvx_port_4)
	begin
		if (!rvx_port_4)
			out_valid <= 1'b0;
		else
			out_valid <= best_valid;
	end

	// Winning value, qualified by out_valid
	always_ff @(posedge rvx_port_0)
	begin
		out_value <= best_value;
	end

endmodule

`default_nettype wire

/* source/window_extreme_tree.sv */
`timescale 1ns/10ps
`default_nettype none
// *********************************************************
// Sample slot buffer and pipelined comparator tree
// Reduces all valid slots to one extreme value
// *********************************************************

module window_extreme_tree
(
	input wire rvx_port_0,
	input wire rvx_port_4,
	input wire slot_write,
	input wire slot_clear,
	input wire [peak_cfg_pkg::slot_index_width-1:0] slot_index,
	input wire [peak_cfg_pkg::sample_width-1:0] sample_data,
	input wire find_min,
	output logic [peak_cfg_pkg::sample_width-1:0] tree_value,
	output logic tree_valid
);

	import peak_cfg_pkg::*;

	genvar lvl;
	genvar node;

	// Slot storage and per-slot valid bits
	logic [sample_width-1:0] slot_data [0:window_slots-1];
	logic [0:window_slots-1] slot_valid;

	// Level 0 is the buffer and level tree_levels the root
	// Upper levels only use their first entries
	logic [0:window_slots-1] lvl_valid [0:tree_levels];
	logic [sample_width-1:0] lvl_value [0:tree_levels][0:window_slots-1];

	// *********************************************************
	// Slot buffer
	// *********************************************************

	// Valid bits cleared all together and set per write
	always_ff @(posedge rvx_port_0 or negedge rvx_port_4)
	begin
		if (!rvx_port_4)
			slot_valid <= '0;
		else if (slot_clear)
			slot_valid <= '0;
		else if (slot_write)
			slot_valid[slot_index] <= 1'b1;
	end

	// Sample payload
	always_ff @(posedge rvx_port_0)
	begin
		if (slot_write)
			slot_data[slot_index] <= sample_data;
	end

	// *********************************************************
	// Comparator tree in groups of four per level
	// *********************************************************

	assign lvl_valid[0] = slot_valid;

	generate
		for (node = 0; node < window_slots; node++)
		begin : g_leaf
			assign lvl_value[0][node] = slot_data[node];
		end

		for (lvl = 0; lvl < tree_levels; lvl++)
		begin : g_level
			for (node = 0; node < 4 ** (tree_levels - 1 - lvl); node++)
			begin : g_node
				cmp4_select u_cmp4_select
				(
					.rvx_port_0(rvx_port_0),
					.rvx_port_4(rvx_port_4),
					.in_valid({lvl_valid[lvl][4*node+3], lvl_valid[lvl][4*node+2],
						lvl_valid[lvl][4*node+1], lvl_valid[lvl][4*node]}),
					.in_value({lvl_value[lvl][4*node+3], lvl_value[lvl][4*node+2],
						lvl_value[lvl][4*node+1], lvl_value[lvl][4*node]}),
					.find_min(find_min),
					.out_valid(lvl_valid[lvl+1][node]),
					.out_value(lvl_value[lvl+1][node])
				);
			end

			// Entries past the last node of this level tie off
			for (node = 4 ** (tree_levels - 1 - lvl); node < window_slots; node++)
			begin : g_unused
				assign lvl_valid[lvl+1][node] = 1'b0;
				assign lvl_value[lvl+1][node] = '0;
			end
		end
	endgenerate

	// Root node
	assign tree_value = lvl_value[tree_levels][0];
	assign tree_valid = lvl_valid[tree_levels][0];

endmodule

`default_nettype wire

/* source/slot_counter.sv */
`timescale 1ns/10ps
`default_nettype none
// *********************************************************
// Slot write index, fill count and drain timer
// *********************************************************

module slot_counter
(
	input wire rvx_port_0,
	input wire rvx_port_4,
	input wire slot_write,
	input wire slot_clear,
	input wire drain_start,
	output logic [peak_cfg_pkg::slot_index_width-1:0] slot_index,
	output logic window_full,
	output logic [peak_cfg_pkg::fill_count_width-1:0] fill_count,
	output logic drain_end
);

	import peak_cfg_pkg::*;

	// Room for tree_latency - 1
	localparam int drain_cnt_width = $clog2(tree_latency + 1);

	logic drain_busy;
	logic [drain_cnt_width-1:0] drain_cnt;

	// Last slot written, index wraps on this push
	assign window_full = slot_write && (slot_index == slot_index_width'(window_slots - 1));

	// Timer expires tree_latency cycles after drain_start
	assign drain_end = drain_busy && (drain_cnt == '0);

	always_ff @(posedge rvx_port_0 or negedge rvx_port_4)
	begin
		if (!rvx_port_4)
		begin
			slot_index <= '0;
			fill_count <= '0;
			drain_busy <= 1'b0;
			drain_cnt <= '0;
		end
		else if (slot_clear)
		begin
			slot_index <= '0;
			fill_count <= '0;
			drain_busy <= 1'b0;
			drain_cnt <= '0;
		end
		else
		begin
			// Index modulo window_slots by natural wrap
			if (slot_write)
				slot_index <= slot_index + 1'b1;
			// Saturates at a full window
			if (slot_write && (fill_count != fill_count_width'(window_slots)))
				fill_count <= fill_count + 1'b1;
			// Drain down-counter
			if (drain_start)
			begin
				drain_busy <= 1'b1;
				drain_cnt <= drain_cnt_width'(tree_latency - 1);
			end
			else if (drain_end)
				drain_busy <= 1'b0;
			else if (drain_busy)
				drain_cnt <= drain_cnt - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/peak_fsm.sv */
`timescale 1ns/10ps
`default_nettype none
// *********************************************************
// Search state machine
// Steers filling, draining, result capture and clearing
// *********************************************************

module peak_fsm
(
	input wire rvx_port_0,
	input wire rvx_port_4,
	input wire op_valid,
	input var peak_ctrl_pkg::peak_op_e op_code,
	input wire sample_push,
	input wire window_full,
	input wire drain_end,
	output peak_ctrl_pkg::peak_state_e state,
	output logic find_min,
	output logic slot_write,
	output logic slot_clear,
	output logic drain_start,
	output logic result_load
);

	import peak_ctrl_pkg::*;

	peak_state_e state_next;
	logic go_fill;
	logic go_drain;

	// Clear is honored in every state
	assign slot_clear = op_valid && (op_code == op_clear);

	// Only pushes during fill reach the buffer
	assign slot_write = sample_push && (state == fill);

	// New search only from idle
	assign go_fill = op_valid && (state == idle) &&
		((op_code == op_find_max) || (op_code == op_find_min));

	// Window full on this push, or host flush
	assign go_drain = (state == fill) &&
		((slot_write && window_full) || (op_valid && (op_code == op_flush)));

	// Tree has settled once the drain timer expires
	assign result_load = drain_end && (state == drain) && !slot_clear;

	always_comb
	begin
		state_next = state;
		if (slot_clear)
			state_next = idle;
		else
		begin
			case (state)
				idle: if (go_fill) state_next = fill;
				fill: if (go_drain) state_next = drain;
				drain: if (result_load) state_next = done;
				// Held until the host clears
				default: state_next = state;
			endcase
		end
	end

	always_ff @(posedge rvx_port_0 or negedge rvx_port_4)
	begin
		if (!rvx_port_4)
		begin
			state <= idle;
			find_min <= 1'b0;
			drain_start <= 1'b0;
		end
		else
		begin
			state <= state_next;
			// Search direction kept for the whole window
			if (go_fill)
				find_min <= (op_code == op_find_min);
			// One pulse on the first drain cycle
			drain_start <= go_drain;
		end
	end

endmodule

`default_nettype wire

/* source/peak_wb_regs.sv */
`timescale 1ns/10ps
`default_nettype none
// *********************************************************
// Wishbone classic slave for the peak finder
// Control, status, sample and result registers
// *********************************************************

module peak_wb_regs
(
	input wire rvx_port_0,
	input wire rvx_port_4,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire [peak_cfg_pkg::addr_width-1:0] wb_adr,
	input wire [peak_cfg_pkg::bus_width-1:0] wb_dat_w,
	input wire [peak_cfg_pkg::sel_width-1:0] wb_sel,
	input var peak_ctrl_pkg::peak_state_e state,
	input wire [peak_cfg_pkg::fill_count_width-1:0] fill_count,
	input wire find_min,
	input wire result_load,
	input wire [peak_cfg_pkg::sample_width-1:0] tree_value,
	input wire tree_valid,
	output logic [peak_cfg_pkg::bus_width-1:0] wb_dat_r,
	output logic wb_ack,
	output logic op_valid,
	output peak_ctrl_pkg::peak_op_e op_code,
	output logic sample_push,
	output logic [peak_cfg_pkg::sample_width-1:0] sample_data
);

	import peak_cfg_pkg::*;
	import peak_ctrl_pkg::*;

	logic wb_req;
	logic ack_next;
	logic req_seen;
	logic wr_strobe;
	logic [bus_width-1:0] rd_word;
	logic [bus_width-1:0] status_word;
	logic [sample_width-1:0] result_value;
	logic result_valid;

	// *********************************************************
	// Bus handshake
	// *********************************************************

	assign wb_req = wb_cyc && wb_stb;
	// One ack per request, blocked until stb drops
	assign ack_next = wb_req && !wb_ack && !req_seen;

	always_ff @(posedge rvx_port_0 or negedge rvx_port_4)
	begin
		if (!rvx_port_4)
		begin
			wb_ack <= 1'b0;
			req_seen <= 1'b0;
			wb_dat_r <= '0;
		end
		else
		begin
			wb_ack <= ack_next;
			if (wb_ack)
				req_seen <= 1'b1;
			else if (!wb_req)
				req_seen <= 1'b0;
			// Read data presented with ack, zero otherwise
			wb_dat_r <= (ack_next && !wb_we) ? rd_word : '0;
		end
	end

	// *********************************************************
	// Write decode, pulses on the acknowledged cycle
	// *********************************************************

	assign wr_strobe = wb_ack && wb_req && wb_we;
	// Opcode lives in byte lane 0
	assign op_valid = wr_strobe && (wb_adr == reg_ctrl) && wb_sel[0];
	// Sample needs all of its byte lanes
	assign sample_push = wr_strobe && (wb_adr == reg_sample) && (&wb_sel[sample_width/8-1:0]);
	assign sample_data = wb_dat_w[sample_width-1:0];

	// Unknown opcode values fall back to op_none
	always_comb
	begin
		case (wb_dat_w[2:0])
			op_find_max: op_code = op_find_max;
			op_find_min: op_code = op_find_min;
			op_flush: op_code = op_flush;
			op_clear: op_code = op_clear;
			default: op_code = op_none;
		endcase
	end

	// *********************************************************
	// Result and status
	// *********************************************************

	always_ff @(posedge rvx_port_0 or negedge rvx_port_4)
	begin
		if (!rvx_port_4)
		begin
			result_value <= '0;
			result_valid <= 1'b0;
		end
		else if (result_load)
		begin
			result_value <= tree_value;
			result_valid <= tree_valid;
		end
	end

	// State, fill count and search direction
	always_comb
	begin
		status_word = '0;
		status_word[1:0] = state;
		status_word[4 +: fill_count_width] = fill_count;
		status_word[12] = find_min;
	end

	// Write-only and unknown addresses read zero
	always_comb
	begin
		rd_word = '0;
		case (wb_adr)
			reg_status: rd_word = status_word;
			reg_result:
			begin
				rd_word[sample_width-1:0] = result_value;
				rd_word[bus_width-1] = result_valid;
			end
			default: rd_word = '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/peak_finder_top.sv */
`timescale 1ns/10ps
`default_nettype none
// *********************************************************
// Windowed peak finder, top level
// *********************************************************

module peak_finder_top
(
	input wire rvx_port_0,
	input wire rvx_port_4,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire [peak_cfg_pkg::addr_width-1:0] wb_adr,
	input wire [peak_cfg_pkg::bus_width-1:0] wb_dat_w,
	input wire [peak_cfg_pkg::sel_width-1:0] wb_sel,
	output logic [peak_cfg_pkg::bus_width-1:0] wb_dat_r,
	output logic wb_ack
);

	import peak_cfg_pkg::*;
	import peak_ctrl_pkg::*;

	// Register block to state machine
	logic op_valid;
	peak_op_e op_code;
	logic sample_push;
	logic [sample_width-1:0] sample_data;

	// State machine outputs
	peak_state_e state;
	logic find_min;
	logic slot_write;
	logic slot_clear;
	logic drain_start;
	logic result_load;

	// Counter and tree outputs
	logic [slot_index_width-1:0] slot_index;
	logic window_full;
	logic [fill_count_width-1:0] fill_count;
	logic drain_end;
	logic [sample_width-1:0] tree_value;
	logic tree_valid;

	peak_wb_regs u_peak_wb_regs
	(
		.rvx_port_0(rvx_port_0),
		.rvx_port_4(rvx_port_4),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_sel(wb_sel),
		.state(state),
		.fill_count(fill_count),
		.find_min(find_min),
		.result_load(result_load),
		.tree_value(tree_value),
		.tree_valid(tree_valid),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.op_valid(op_valid),
		.op_code(op_code),
		.sample_push(sample_push),
		.sample_data(sample_data)
	);

	peak_fsm u_peak_fsm
	(
		.rvx_port_0(rvx_port_0),
		.rvx_port_4(rvx_port_4),
		.op_valid(op_valid),
		.op_code(op_code),
		.sample_push(sample_push),
		.window_full(window_full),
		.drain_end(drain_end),
		.state(state),
		.find_min(find_min),
		.slot_write(slot_write),
		.slot_clear(slot_clear),
		.drain_start(drain_start),
		.result_load(result_load)
	);

	slot_counter u_slot_counter
	(
		.rvx_port_0(rvx_port_0),
		.rvx_port_4(rvx_port_4),
		.slot_write(slot_write),
		.slot_clear(slot_clear),
		.drain_start(drain_start),
		.slot_index(slot_index),
		.window_full(window_full),
		.fill_count(fill_count),
		.drain_end(drain_end)
	);

	window_extreme_tree u_window_extreme_tree
	(
		.rvx_port_0(rvx_port_0),
		.rvx_port_4(rvx_port_4),
		.slot_write(slot_write),
		.slot_clear(slot_clear),
		.slot_index(slot_index),
		.sample_data(sample_data),
		.find_min(find_min),
		.tree_value(tree_value),
		.tree_valid(tree_valid)
	);

endmodule

`default_nettype wire

/* bench/peak_finder_checker.sv */
`timescale 1ns/10ps
`default_nettype none
// ************************************************************
// Bus and protocol checker for the peak finder
// Bound into the top level
// ************************************************************

module peak_finder_checker
(
	input wire rvx_port_0,
	input wire rvx_port_4,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_ack,
	input var peak_ctrl_pkg::peak_state_e state,
	input wire result_load,
	input wire slot_clear
);

	import peak_ctrl_pkg::*;

	// Failed assertions so far, watched by the testbench
	int error_count = 0;
	// A result was captured since the last clear
	logic loaded;

	always_ff @(posedge rvx_port_0 or negedge rvx_port_4)
	begin
		if (!rvx_port_4)
			loaded <= 1'b0;
		else if (slot_clear)
			loaded <= 1'b0;
		else if (result_load)
			loaded <= 1'b1;
	end

	// ************************************************************
	// Wishbone handshake
	// ************************************************************

	// Ack only answers a request seen in the cycle before
	ack_after_request: assert property (@(posedge rvx_port_0) disable iff (!rvx_port_4)
		wb_ack |-> $past(wb_cyc && wb_stb))
	else
	begin
		error_count = error_count + 1;
		$error("ack raised without a request in the previous cycle");
	end

	// Single-cycle ack
	ack_one_cycle: assert property (@(posedge rvx_port_0) disable iff (!rvx_port_4)
		wb_ack |=> !wb_ack)
	else
	begin
		error_count = error_count + 1;
		$error("ack held for two consecutive cycles");
	end

	// ************************************************************
	// Search sequencing
	// ************************************************************

	// Done only after a result capture since the last clear
	done_after_load: assert property (@(posedge rvx_port_0) disable iff (!rvx_port_4)
		(state == done) |-> loaded)
	else
	begin
		error_count = error_count + 1;
		$error("state is done without a result capture since the last clear");
	end

endmodule

bind peak_finder_top peak_finder_checker u_peak_finder_checker
(
	.rvx_port_0(rvx_port_0),
	.rvx_port_4(rvx_port_4),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_ack(wb_ack),
	.state(state),
	.result_load(result_load),
	.slot_clear(slot_clear)
);

`default_nettype wire

/* bench/peak_finder_tb.sv */
`timescale 1ns/10ps
`default_nettype none
// ************************************************************
// Testbench for the windowed peak finder
// Bus tasks, reference model, stimulus and verdict
// ************************************************************

module peak_finder_tb;

	import peak_cfg_pkg::*;
	import peak_ctrl_pkg::*;

	// Budget of four cycles per bus access
	localparam int clk_period = 10;
	localparam int access_ns = 4 * clk_period;
	// About a hundred accesses in all with five times margin
	localparam int watchdog_ns = 500 * access_ns;
	localparam int ack_limit = 16;
	localparam int poll_limit = 32;

	logic rvx_port_0;
	logic rvx_port_4;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [addr_width-1:0] wb_adr;
	logic [bus_width-1:0] wb_dat_w;
	logic [sel_width-1:0] wb_sel;
	logic [bus_width-1:0] wb_dat_r;
	logic wb_ack;

	// Samples accepted in the current window
	logic [sample_width-1:0] model_q [$];
	integer seed;
	logic [bus_width-1:0] rd_data;
	logic [bus_width-1:0] prev_result;

	peak_finder_top u_peak_finder_top
	(
		.rvx_port_0(rvx_port_0),
		.rvx_port_4(rvx_port_4),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_sel(wb_sel),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack)
	);

	initial
	begin
		rvx_port_0 = 1'b0;
		forever #(clk_period / 2) rvx_port_0 = ~rvx_port_0;
	end

	initial
	begin
		#(watchdog_ns);
		fail_stop("watchdog expired before the tests finished");
	end

	// Any failed bound assertion ends the run
	always @(negedge rvx_port_0)
	begin
		if (u_peak_finder_top.u_peak_finder_checker.error_count != 0)
			fail_stop("bound checker reported a protocol assertion failure");
	end

	// ************************************************************
	// Helpers
	// ************************************************************

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_word(input string what, input logic [bus_width-1:0] expected,
		input logic [bus_width-1:0] actual);
		assert (actual === expected)
		else
			fail_stop($sformatf("mismatch wb_dat_r %s expected %h actual %h",
				what, expected, actual));
	endtask

	// Ack is sampled at the falling edge and the request dropped on the next rising edge
	task automatic wait_ack(output logic [bus_width-1:0] data);
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge rvx_port_0);
			cycles++;
		end
		while (!wb_ack && (cycles < ack_limit));
		if (!wb_ack)
			fail_stop("bus access was never acknowledged");
		data = wb_dat_r;
		@(posedge rvx_port_0);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic wb_write(input logic [addr_width-1:0] addr, input logic [bus_width-1:0] data);
		logic [bus_width-1:0] unused;
		@(posedge rvx_port_0);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b1;
		wb_adr <= addr;
		wb_dat_w <= data;
		wb_sel <= '1;
		wait_ack(unused);
	endtask

	task automatic wb_read(input logic [addr_width-1:0] addr, output logic [bus_width-1:0] data);
		@(posedge rvx_port_0);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b0;
		wb_adr <= addr;
		wb_dat_w <= '0;
		wb_sel <= '1;
		wait_ack(data);
	endtask

	// Push one sample and record it in the model
	task automatic push_sample(input logic [sample_width-1:0] value);
		wb_write(reg_sample, bus_width'(value));
		model_q.push_back(value);
	endtask

	task automatic push_random(input int count, input logic [sample_width-1:0] mask);
		logic [31:0] rnd;
		for (int i = 0; i < count; i++)
		begin
			rnd = $random(seed);
			push_sample(rnd[sample_width-1:0] & mask);
		end
	endtask

	// New search with an empty model window
	task automatic start_search(input peak_op_e op);
		wb_write(reg_ctrl, bus_width'(op));
		model_q.delete();
	endtask

	// Poll status until the state field reads done
	task automatic wait_done();
		logic [bus_width-1:0] word;
		int polls;
		word = '0;
		polls = 0;
		while ((word[1:0] != done) && (polls < poll_limit))
		begin
			wb_read(reg_status, word);
			polls++;
		end
		if (word[1:0] != done)
			fail_stop("search did not reach done while polling status");
	endtask

	// Largest or smallest accepted sample
	function automatic logic [sample_width-1:0] model_extreme(input logic use_min);
		logic [sample_width-1:0] best;
		best = model_q[0];
		foreach (model_q[i])
		begin
			if (use_min ? (model_q[i] < best) : (model_q[i] > best))
				best = model_q[i];
		end
		return best;
	endfunction

	// Result layout with the value low and valid in bit 31
	function automatic logic [bus_width-1:0] result_expect(input logic valid,
		input logic [sample_width-1:0] value);
		logic [bus_width-1:0] word;
		word = '0;
		word[sample_width-1:0] = value;
		word[bus_width-1] = valid;
		return word;
	endfunction

	// Status layout holding state, fill count and direction
	function automatic logic [bus_width-1:0] status_expect(input logic [1:0] st,
		input int fill_cnt, input logic dir_min);
		logic [bus_width-1:0] word;
		word = '0;
		word[1:0] = st;
		word[8:4] = fill_cnt[4:0];
		word[12] = dir_min;
		return word;
	endfunction

	// ************************************************************
	// Stimulus
	// ************************************************************

	initial
	begin
		seed = 32'h0855_fff7;
		rvx_port_4 = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_sel = '0;
		rd_data = '0;
		prev_result = '0;
		repeat (16) @(posedge rvx_port_0);
		rvx_port_4 <= 1'b1;

		// Reset values and zero reads of write-only and unknown addresses
		wb_read(reg_status, rd_data);
		check_word("status after reset", status_expect(idle, 0, 1'b0), rd_data);
		wb_read(reg_result, rd_data);
		check_word("result after reset", '0, rd_data);
		wb_read(reg_ctrl, rd_data);
		check_word("ctrl readback", '0, rd_data);
		wb_read(reg_sample, rd_data);
		check_word("sample readback", '0, rd_data);
		wb_write(4'h2, 32'hFFFF_FFFF);
		wb_read(4'h2, rd_data);
		check_word("unknown address readback", '0, rd_data);

		// Maximum of a full window
		start_search(op_find_max);
		push_random(16, 16'hFFFF);
		wait_done();
		wb_read(reg_result, rd_data);
		check_word("max of full window", result_expect(1'b1, model_extreme(1'b0)), rd_data);
		wb_read(reg_status, rd_data);
		check_word("status after max window", status_expect(done, 16, 1'b0), rd_data);

		// Minimum of a full window
		wb_write(reg_ctrl, bus_width'(op_clear));
		start_search(op_find_min);
		push_random(16, 16'hFFFF);
		wait_done();
		wb_read(reg_result, rd_data);
		check_word("min of full window", result_expect(1'b1, model_extreme(1'b1)), rd_data);
		wb_read(reg_status, rd_data);
		check_word("status after min window", status_expect(done, 16, 1'b1), rd_data);

		// Old window of all ones before a flushed partial window
		wb_write(reg_ctrl, bus_width'(op_clear));
		start_search(op_find_max);
		for (int i = 0; i < 16; i++)
			push_sample(16'hFFFF);
		wait_done();
		wb_read(reg_result, rd_data);
		check_word("all ones window", result_expect(1'b1, 16'hFFFF), rd_data);
		wb_write(reg_ctrl, bus_width'(op_clear));
		start_search(op_find_max);
		push_random(5, 16'h7FFF);
		wb_write(reg_ctrl, bus_width'(op_flush));
		wait_done();
		wb_read(reg_result, rd_data);
		check_word("max after flush", result_expect(1'b1, model_extreme(1'b0)), rd_data);
		prev_result = result_expect(1'b1, model_extreme(1'b0));
		wb_read(reg_status, rd_data);
		check_word("status after flush", status_expect(done, 5, 1'b0), rd_data);

		// Pushes in done and in idle are dropped
		wb_write(reg_sample, 32'h0000_FFFF);
		wb_read(reg_status, rd_data);
		check_word("status after push in done", status_expect(done, 5, 1'b0), rd_data);
		wb_read(reg_result, rd_data);
		check_word("result after push in done", prev_result, rd_data);
		wb_write(reg_ctrl, bus_width'(op_clear));
		wb_write(reg_sample, 32'h0000_FFFF);
		wb_read(reg_status, rd_data);
		check_word("status after push in idle", status_expect(idle, 0, 1'b0), rd_data);
		wb_read(reg_result, rd_data);
		check_word("result after push in idle", prev_result, rd_data);

		// Flush of an empty window
		start_search(op_find_max);
		wb_write(reg_ctrl, bus_width'(op_flush));
		wait_done();
		wb_read(reg_result, rd_data);
		check_word("empty window result", result_expect(1'b0, 16'h0000), rd_data);
		wb_read(reg_status, rd_data);
		check_word("status after empty flush", status_expect(done, 0, 1'b0), rd_data);

		// Let the last bus cycles reach the checker
		repeat (4) @(posedge rvx_port_0);
		if (u_peak_finder_top.u_peak_finder_checker.error_count == 0)
		begin
			$display("TEST RESULT: PASS");
			$finish;
		end
		else
			fail_stop("bound checker reported a protocol assertion failure");
	end

endmodule

`default_nettype wire

/* peak_finder_top.f */
source/peak_cfg_pkg.sv
source/peak_ctrl_pkg.sv
source/cmp4_select.sv
source/window_extreme_tree.sv
source/slot_counter.sv
source/peak_fsm.sv
source/peak_wb_regs.sv
source/peak_finder_top.sv
bench/peak_finder_checker.sv
bench/peak_finder_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the peak finder testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module peak_finder_tb -f peak_finder_top.f -o Vpeak_finder_tb; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vpeak_finder_tb +verilator+error+limit+100 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$log_file"; then
	echo "simulation passed"
	exit 0
fi

echo "pass message not found in $log_file"
exit 1
